// File: tb.f
src/flash_phy_pkg.sv
src/flash_phy_seq_fifo.sv
src/flash_phy_rsp_buf.sv
src/flash_op_timer.sv
src/flash_bank_array.sv
src/flash_bank_fsm.sv
src/flash_bank_core.sv
src/flash_phy.sv
bench/tb_clk_gen.sv
bench/flash_phy_tb.sv

// File: bench/flash_phy_tb.sv
`timescale 1ns/10ps
`default_nettype none

module flash_phy_tb
  import flash_phy_pkg::*;
();

  localparam int unsigned READ_CYCLES  = 2;
  localparam int unsigned PROG_CYCLES  = 4;
  localparam int unsigned ERASE_CYCLES = 6;
  localparam int unsigned RESET_CYCLES = 4;
  localparam int unsigned NUM_ENTRIES  = 20;

  logic       clk;
  logic       reset_i;
  logic       host_req_i;
  flash_req_t host_req_data_i;
  logic       host_req_rdy_o;
  logic       host_done_o;
  flash_rsp_t host_rsp_o;

  // stimulus table with one request and its expected response per row
  string      names [NUM_ENTRIES];
  flash_req_t reqs [NUM_ENTRIES];
  flash_rsp_t exps [NUM_ENTRIES];
  bit         b2b [NUM_ENTRIES];
  int         num_added = 0;

  // response bookkeeping shared by driver and monitor
  int cycle = 0;
  int rsp_count = 0;
  bit iso_active = 1'b0;
  int iso_idx = 0;
  int iso_due = 0;

  tb_clk_gen u_clk_gen (
    .clk_o (clk)
  );

  flash_phy #(
    .READ_CYCLES  (READ_CYCLES),
    .PROG_CYCLES  (PROG_CYCLES),
    .ERASE_CYCLES (ERASE_CYCLES)
  ) u_flash_phy (
    .clk_i           (clk),
    .reset_i         (reset_i),
    .host_req_i      (host_req_i),
    .host_req_data_i (host_req_data_i),
    .host_req_rdy_o  (host_req_rdy_o),
    .host_done_o     (host_done_o),
    .host_rsp_o      (host_rsp_o)
  );

  //////////////////////////////////////////////////
  // helpers and compare tasks
  //////////////////////////////////////////////////

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_rsp(string name, flash_rsp_t exp, flash_rsp_t act);
    if (act !== exp) begin
      $display("Mismatch in %s: expected rdata=%h err=%b, actual rdata=%h err=%b",
               name, exp.rdata, exp.err, act.rdata, act.err);
      abort_run();
    end
  endtask

  task automatic check_ready(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("Mismatch in %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // latency of each operation as the host should see it
  function automatic int op_latency(flash_op_e op);
    case (op)
      OP_READ: return READ_CYCLES;
      OP_PROG: return PROG_CYCLES;
      default: return ERASE_CYCLES;
    endcase
  endfunction

  task automatic add_entry(string name, flash_op_e op, logic [ADDR_W-1:0] addr,
                           logic [DATA_W-1:0] wdata, logic [DATA_W-1:0] exp_rdata,
                           logic exp_err, bit back_to_back);
    names[num_added]       = name;
    reqs[num_added].op     = op;
    reqs[num_added].addr   = addr;
    reqs[num_added].wdata  = wdata;
    exps[num_added].rdata  = exp_rdata;
    exps[num_added].err    = exp_err;
    b2b[num_added]         = back_to_back;
    num_added++;
  endtask

  // expected values follow the flash rules where programming only clears bits
  task automatic build_table();
    add_entry("reset_read", OP_READ, 5'h03, 16'h0000, 16'hffff, 1'b0, 1'b0);
    add_entry("prog_0f0f", OP_PROG, 5'h01, 16'h0f0f, 16'h0f0f, 1'b0, 1'b0);
    add_entry("read_0f0f", OP_READ, 5'h01, 16'h0000, 16'h0f0f, 1'b0, 1'b0);
    // the second program clears bits 11..8 and raises nothing
    add_entry("prog_000f", OP_PROG, 5'h01, 16'h000f, 16'h000f, 1'b0, 1'b0);
    add_entry("read_000f", OP_READ, 5'h01, 16'h0000, 16'h000f, 1'b0, 1'b0);
    // raising bits 15..12 from zero is refused and the word stays
    add_entry("prog_set_bit", OP_PROG, 5'h01, 16'hf000, 16'h000f, 1'b1, 1'b0);
    add_entry("read_after_err", OP_READ, 5'h01, 16'h0000, 16'h000f, 1'b0, 1'b0);
    // word 5 lives in page 1 next to the erased page 0
    add_entry("prog_neighbour", OP_PROG, 5'h05, 16'h1234, 16'h1234, 1'b0, 1'b0);
    add_entry("erase_page0", OP_ERASE, 5'h02, 16'h0000, 16'hffff, 1'b0, 1'b0);
    add_entry("erase_read_w0", OP_READ, 5'h00, 16'h0000, 16'hffff, 1'b0, 1'b0);
    add_entry("erase_read_w1", OP_READ, 5'h01, 16'h0000, 16'hffff, 1'b0, 1'b0);
    add_entry("erase_read_w2", OP_READ, 5'h02, 16'h0000, 16'hffff, 1'b0, 1'b0);
    add_entry("erase_read_w3", OP_READ, 5'h03, 16'h0000, 16'hffff, 1'b0, 1'b0);
    add_entry("neighbour_kept", OP_READ, 5'h05, 16'h0000, 16'h1234, 1'b0, 1'b0);
    // bank 1 read finishes first but must come back after the bank 0 erase
    add_entry("prog_b1", OP_PROG, 5'h12, 16'ha5a5, 16'ha5a5, 1'b0, 1'b0);
    add_entry("ooo_erase_b0", OP_ERASE, 5'h04, 16'h0000, 16'hffff, 1'b0, 1'b0);
    add_entry("ooo_read_b1", OP_READ, 5'h12, 16'h0000, 16'ha5a5, 1'b0, 1'b1);
    add_entry("same_bank_prog", OP_PROG, 5'h13, 16'h3c3c, 16'h3c3c, 1'b0, 1'b0);
    add_entry("same_bank_read", OP_READ, 5'h13, 16'h0000, 16'h3c3c, 1'b0, 1'b1);
    add_entry("isolated_read", OP_READ, 5'h0c, 16'h0000, 16'hffff, 1'b0, 1'b0);
  endtask

  //////////////////////////////////////////////////
  // driver, monitor and watchdog
  //////////////////////////////////////////////////

  always @(posedge clk) cycle <= cycle + 1;

  initial begin : driver
    int  accept_cycle;
    bit  exp_rdy;
    host_req_i      = 1'b0;
    host_req_data_i = '0;
    reset_i         = 1'b1;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset_i = 1'b0;
    @(negedge clk);
    check_ready("reset_rdy", 1'b1, host_req_rdy_o);
    check_ready("reset_done", 1'b0, host_done_o);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      // an isolated request waits until every earlier response is back
      if (!b2b[i]) begin
        wait (rsp_count >= i);
        @(posedge clk);
        #1;
      end
      host_req_i      = 1'b1;
      host_req_data_i = reqs[i];
      @(negedge clk);
      // a back-to-back request stalls only when its bank is still busy
      if (b2b[i]) begin
        exp_rdy = (reqs[i].addr[ADDR_W-1] != reqs[i-1].addr[ADDR_W-1]);
        check_ready({names[i], "_rdy"}, exp_rdy, host_req_rdy_o);
      end
      while (!host_req_rdy_o) @(negedge clk);
      accept_cycle = cycle;
      @(posedge clk);
      #1;
      host_req_i = 1'b0;
      if (!b2b[i]) begin
        iso_idx    = i;
        iso_due    = accept_cycle + op_latency(reqs[i].op) + 1;
        iso_active = 1'b1;
      end
    end
    wait (rsp_count == NUM_ENTRIES);
    repeat (4) @(negedge clk);
    $display("PASS: all tests");
    $finish;
  end

  // outputs are sampled at the falling edge where they have settled
  always @(negedge clk) begin
    if (iso_active) begin
      // done must stay low until the exact latency of an isolated request
      if (cycle < iso_due) begin
        check_ready({names[iso_idx], "_early_done"}, 1'b0, host_done_o);
      end else begin
        check_ready({names[iso_idx], "_latency"}, 1'b1, host_done_o);
        iso_active = 1'b0;
      end
    end
    if (!reset_i && host_done_o) begin
      if (rsp_count >= NUM_ENTRIES) begin
        $display("ERROR: a response arrived with no request outstanding");
        abort_run();
      end else begin
        check_rsp(names[rsp_count], exps[rsp_count], host_rsp_o);
        rsp_count++;
      end
    end
  end

  initial begin : watchdog
    repeat (NUM_ENTRIES * (ERASE_CYCLES + 4) + RESET_CYCLES) @(posedge clk);
    $display("ERROR: watchdog expired, responses stopped arriving");
    abort_run();
  end

endmodule

`default_nettype wire

// File: bench/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned HALF_PERIOD_NS = 2
) (
  output logic clk_o
);

  // free running clock, 4 ns period with the default half period
  initial clk_o = 1'b0;
  always #(HALF_PERIOD_NS) clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: src/flash_phy.sv
`timescale 1ns/10ps
`default_nettype none

module flash_phy
  import flash_phy_pkg::*;
#(
  parameter int unsigned READ_CYCLES  = 2,
  parameter int unsigned PROG_CYCLES  = 4,
  parameter int unsigned ERASE_CYCLES = 6,
  parameter int unsigned SEQ_DEPTH    = NUM_BANKS
) (
  input  wire         clk_i,
  input  wire         reset_i,
  input  logic        host_req_i,
  input  flash_req_t  host_req_data_i,
  output logic        host_req_rdy_o,
  output logic        host_done_o,
  output flash_rsp_t  host_rsp_o
);

  //////////////////////////////////////////////////
  // bank decode and request acceptance
  //////////////////////////////////////////////////

  logic [BANK_W-1:0]                 host_bank_sel;
  logic [BANK_W-1:0]                 head_bank;
  logic                              seq_full;
  logic                              seq_pending;
  logic                              host_accept;
  logic [NUM_BANKS-1:0]              bank_idle;
  logic [NUM_BANKS-1:0]              bank_done;
  logic [NUM_BANKS-1:0]              buf_empty;
  logic [NUM_BANKS-1:0]              buf_valid;
  logic [NUM_BANKS-1:0]              buf_pop;
  flash_rsp_t [NUM_BANKS-1:0]        bank_rsp;
  flash_rsp_t [NUM_BANKS-1:0]        buf_rsp;
  bank_req_t                         bank_req;

  // the top address bit picks the bank
  assign host_bank_sel = host_req_data_i.addr[ADDR_W-1 -: BANK_W];

  // a bank takes new work only when it is idle and its previous response is gone
  assign host_req_rdy_o = bank_idle[host_bank_sel] & buf_empty[host_bank_sel] & ~seq_full;
  assign host_accept    = host_req_i & host_req_rdy_o;

  // strip the bank bit before the request reaches a core
  assign bank_req.op    = host_req_data_i.op;
  assign bank_req.addr  = host_req_data_i.addr[WORD_ADDR_W-1:0];
  assign bank_req.wdata = host_req_data_i.wdata;

  // responses leave only in issue order, led by the head of the sequence
  assign host_done_o = seq_pending & buf_valid[head_bank];
  assign host_rsp_o  = buf_rsp[head_bank];

  flash_phy_seq_fifo #(
    .SEQ_DEPTH (SEQ_DEPTH)
  ) u_seq_fifo (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .push_i      (host_accept),
    .bank_i      (host_bank_sel),
    .pop_i       (host_done_o),
    .full_o      (seq_full),
    .pending_o   (seq_pending),
    .head_bank_o (head_bank)
  );

  //////////////////////////////////////////////////
  // per bank core with its response holder
  //////////////////////////////////////////////////

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_banks

    // pop only the holder whose bank is at the head
    assign buf_pop[b] = host_done_o & (head_bank == BANK_W'(b));

    flash_bank_core #(
      .READ_CYCLES  (READ_CYCLES),
      .PROG_CYCLES  (PROG_CYCLES),
      .ERASE_CYCLES (ERASE_CYCLES)
    ) u_core (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .req_i      (host_accept & (host_bank_sel == BANK_W'(b))),
      .req_data_i (bank_req),
      .idle_o     (bank_idle[b]),
      .done_o     (bank_done[b]),
      .rsp_o      (bank_rsp[b])
    );

    flash_phy_rsp_buf u_rsp_buf (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .wr_i    (bank_done[b]),
      .rsp_i   (bank_rsp[b]),
      .pop_i   (buf_pop[b]),
      .empty_o (buf_empty[b]),
      .valid_o (buf_valid[b]),
      .rsp_o   (buf_rsp[b])
    );
  end

endmodule

`default_nettype wire

// File: src/flash_bank_core.sv
`timescale 1ns/10ps
`default_nettype none

module flash_bank_core
  import flash_phy_pkg::*;
#(
  parameter int unsigned READ_CYCLES  = 2,
  parameter int unsigned PROG_CYCLES  = 4,
  parameter int unsigned ERASE_CYCLES = 6
) (
  input  wire        clk_i,
  input  wire        reset_i,
  input  logic       req_i,
  input  bank_req_t  req_data_i,
  output logic       idle_o,
  output logic       done_o,
  output flash_rsp_t rsp_o
);

  logic      timer_load;
  logic      timer_expired;
  logic      commit;
  flash_op_e timer_op;
  bank_req_t cmd;

  // the commit cycle is the one cycle the response is valid
  assign done_o = commit;

  flash_bank_fsm u_fsm (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_i      (req_i),
    .req_data_i (req_data_i),
    .expired_i  (timer_expired),
    .load_o     (timer_load),
    .op_o       (timer_op),
    .commit_o   (commit),
    .cmd_o      (cmd),
    .idle_o     (idle_o)
  );

  flash_op_timer #(
    .READ_CYCLES  (READ_CYCLES),
    .PROG_CYCLES  (PROG_CYCLES),
    .ERASE_CYCLES (ERASE_CYCLES)
  ) u_timer (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .load_i    (timer_load),
    .op_i      (timer_op),
    .expired_o (timer_expired)
  );

  flash_bank_array u_array (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .commit_i (commit),
    .cmd_i    (cmd),
    .rsp_o    (rsp_o)
  );

endmodule

`default_nettype wire

// File: src/flash_bank_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module flash_bank_fsm
  import flash_phy_pkg::*;
(
  input  wire       clk_i,
  input  wire       reset_i,
  input  logic      req_i,
  input  bank_req_t req_data_i,
  input  logic      expired_i,
  output logic      load_o,
  output flash_op_e op_o,
  output logic      commit_o,
  output bank_req_t cmd_o,
  output logic      idle_o
);

  bank_state_e state;
  bank_state_e state_next;
  bank_req_t   cmd_q;

  // the timer is loaded on the same edge that takes the request
  assign load_o   = (state == ST_IDLE) & req_i;
  assign op_o     = req_data_i.op;
  assign commit_o = (state == ST_COMMIT);
  assign idle_o   = (state == ST_IDLE);
  assign cmd_o    = cmd_q;

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (req_i) begin
          state_next = ST_BUSY;
        end
      end
      ST_BUSY: begin
        // stay until the latency of the operation has elapsed
        if (expired_i) begin
          state_next = ST_COMMIT;
        end
      end
      ST_COMMIT: begin
        state_next = ST_IDLE;
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // the command is held stable for the array until commit
  always_ff @(posedge clk_i) begin
    if (load_o) begin
      cmd_q <= req_data_i;
    end
  end

endmodule

`default_nettype wire

// File: src/flash_bank_array.sv
`timescale 1ns/10ps
`default_nettype none

module flash_bank_array
  import flash_phy_pkg::*;
(
  input  wire        clk_i,
  input  wire        reset_i,
  input  logic       commit_i,
  input  bank_req_t  cmd_i,
  output flash_rsp_t rsp_o
);

  localparam int unsigned NUM_WORDS = 2 ** WORD_ADDR_W;
  localparam int unsigned PAGE_WORDS = 2 ** PAGE_W;

  logic [DATA_W-1:0]             mem [NUM_WORDS];
  logic [DATA_W-1:0]             word;
  logic                          prog_ok;
  logic [WORD_ADDR_W-PAGE_W-1:0] page;

  assign word = mem[cmd_i.addr];
  assign page = cmd_i.addr[WORD_ADDR_W-1:PAGE_W];

  // programming may only clear bits, any bit raised from zero is refused
  assign prog_ok = ((~word & cmd_i.wdata) == '0);

  // the response shows the word as it will look after the commit
  always_comb begin
    rsp_o.rdata = word;
    rsp_o.err   = 1'b0;
    case (cmd_i.op)
      OP_PROG: begin
        rsp_o.rdata = prog_ok ? (word & cmd_i.wdata) : word;
        rsp_o.err   = ~prog_ok;
      end
      OP_ERASE: rsp_o.rdata = '1;
      default: rsp_o.rdata = word;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // a fresh device reads back as erased
      for (int i = 0; i < NUM_WORDS; i++) begin
        mem[i] <= '1;
      end
    end else if (commit_i) begin
      if (cmd_i.op == OP_PROG && prog_ok) begin
        mem[cmd_i.addr] <= word & cmd_i.wdata;
      end else if (cmd_i.op == OP_ERASE) begin
        for (int j = 0; j < PAGE_WORDS; j++) begin
          mem[{page, PAGE_W'(j)}] <= '1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/flash_op_timer.sv
`timescale 1ns/10ps
`default_nettype none

module flash_op_timer
  import flash_phy_pkg::*;
#(
  parameter int unsigned READ_CYCLES  = 2,
  parameter int unsigned PROG_CYCLES  = 4,
  parameter int unsigned ERASE_CYCLES = 6
) (
  input  wire       clk_i,
  input  wire       reset_i,
  input  logic      load_i,
  input  flash_op_e op_i,
  output logic      expired_o
);

  // counter is sized for the longest of the three latencies
  localparam int unsigned MAX_RP = (READ_CYCLES > PROG_CYCLES) ? READ_CYCLES : PROG_CYCLES;
  localparam int unsigned MAX_CYCLES = (MAX_RP > ERASE_CYCLES) ? MAX_RP : ERASE_CYCLES;
  localparam int unsigned CNT_W = $clog2(MAX_CYCLES + 1);

  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] load_val;

  always_comb begin
    case (op_i)
      OP_READ: load_val = CNT_W'(READ_CYCLES);
      OP_PROG: load_val = CNT_W'(PROG_CYCLES);
      default: load_val = CNT_W'(ERASE_CYCLES);
    endcase
  end

  // expiry shows while the count sits at one, then the counter parks at zero
  assign expired_o = (count == CNT_W'(1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count <= '0;
    end else if (load_i) begin
      count <= load_val;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/flash_phy_rsp_buf.sv
`timescale 1ns/10ps
`default_nettype none

module flash_phy_rsp_buf
  import flash_phy_pkg::*;
(
  input  wire        clk_i,
  input  wire        reset_i,
  input  logic       wr_i,
  input  flash_rsp_t rsp_i,
  input  logic       pop_i,
  output logic       empty_o,
  output logic       valid_o,
  output flash_rsp_t rsp_o
);

  logic       valid_q;
  flash_rsp_t rsp_q;

  // an empty holder lets a new response straight through
  assign empty_o = ~valid_q;
  assign valid_o = valid_q | wr_i;
  assign rsp_o   = valid_q ? rsp_q : rsp_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (valid_q) begin
      valid_q <= ~pop_i;
    end else begin
      // keep the response only if the host did not take it this cycle
      valid_q <= wr_i & ~pop_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!valid_q && wr_i) begin
      rsp_q <= rsp_i;
    end
  end

endmodule

`default_nettype wire

// File: src/flash_phy_seq_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module flash_phy_seq_fifo
  import flash_phy_pkg::*;
#(
  parameter int unsigned SEQ_DEPTH = NUM_BANKS
) (
  input  wire               clk_i,
  input  wire               reset_i,
  input  logic              push_i,
  input  logic [BANK_W-1:0] bank_i,
  input  logic              pop_i,
  output logic              full_o,
  output logic              pending_o,
  output logic [BANK_W-1:0] head_bank_o
);

  localparam int unsigned PTR_W = (SEQ_DEPTH > 1) ? $clog2(SEQ_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(SEQ_DEPTH + 1);

  // bank index of every outstanding request, oldest at the read pointer
  logic [BANK_W-1:0] entries [SEQ_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              do_push;
  logic              do_pop;

  assign full_o      = (count == CNT_W'(SEQ_DEPTH));
  assign pending_o   = (count != '0);
  assign head_bank_o = entries[rd_ptr];

  // both sides may move in one cycle
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & pending_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap by compare so any depth works
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(SEQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(SEQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      entries[wr_ptr] <= bank_i;
    end
  end

endmodule

`default_nettype wire

// File: src/flash_phy_pkg.sv
`default_nettype none

package flash_phy_pkg;

  // two banks, selected by the top bit of the host address
  localparam int unsigned NUM_BANKS = 2;
  localparam int unsigned BANK_W = 1;

  // each bank holds 16 words grouped in pages of four
  localparam int unsigned WORD_ADDR_W = 4;
  localparam int unsigned ADDR_W = BANK_W + WORD_ADDR_W;
  localparam int unsigned PAGE_W = 2;
  localparam int unsigned DATA_W = 16;

  typedef enum logic [1:0] {
    OP_READ  = 2'b00,
    OP_PROG  = 2'b01,
    OP_ERASE = 2'b10
  } flash_op_e;

  typedef enum logic [1:0] {
    ST_IDLE   = 2'b00,
    ST_BUSY   = 2'b01,
    ST_COMMIT = 2'b10
  } bank_state_e;

  // request as issued by the host, the address still carries the bank bit
  typedef struct packed {
    flash_op_e               op;
    logic [ADDR_W-1:0]       addr;
    logic [DATA_W-1:0]       wdata;
  } flash_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } flash_rsp_t;

  // request after bank decode, only the in-bank word address is kept
  typedef struct packed {
    flash_op_e               op;
    logic [WORD_ADDR_W-1:0]  addr;
    logic [DATA_W-1:0]       wdata;
  } bank_req_t;

endpackage

`default_nettype wire
